// File: tb.f
logic/rv_pkg.sv
logic/rv_control.sv
logic/rv_regfile.sv
logic/rv_imm_gen.sv
logic/rv_alu.sv
logic/rv_pc_unit.sv
logic/rv_lsu.sv
logic/rv_core.sv
sim/rv_core_sva.sv
sim/rv_core_tb.sv

// File: run.sh
#!/bin/sh
# build and run the rv_core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module rv_core_tb \
    -f tb.f -o rv_core_sim > build.log 2>&1 \
    || { echo "build failed, see build.log"; exit 1; }

./obj_dir/rv_core_sim > sim.log 2>&1 \
    || { echo "simulation exited with an error, see sim.log"; exit 1; }

! grep -q "CHECKS FAILED" sim.log && echo "test passed" \
    || { echo "test failed, see sim.log"; exit 1; }

// File: sim/rv_core_tb.sv
`timescale 1ns/100ps

module rv_core_tb import rv_pkg::*; ();
    logic            clk;
    logic            rst;
    logic [XLEN-1:0] imem_addr;
    logic [31:0]     imem_data;
    logic [XLEN-1:0] retire_pc;
    logic            wb_we;
    logic [4:0]      wb_addr;
    logic [XLEN-1:0] wb_data;
    logic            illegal;

    logic [31:0]     rom [64];
    logic            exp_we [64];
    logic [4:0]      exp_rd [64];
    logic [XLEN-1:0] exp_val [64];
    logic [XLEN-1:0] exp_next [64];
    logic [XLEN-1:0] sreg [32];       // shadow registers
    logic [7:0]      smem [2048];     // shadow data memory in bytes
    int              pcw;
    int              errors;
    int              checks;
    int              prev_idx;
    int              cur_idx;
    bit              have_prev;

    rv_core UUT (.*);

    bind rv_core rv_core_sva u_sva (.*);

    assign imem_data = rom[imem_addr[7:2]];  // combinational rom

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [XLEN-1:0] sext12(input logic [11:0] v);
        return {{(XLEN-12){v[11]}}, v};
    endfunction

    function automatic logic [31:0] enc_i(input logic [6:0] op, input logic [4:0] rd,
                                          input logic [2:0] f3, input logic [4:0] rs1,
                                          input logic [11:0] imm);
        return {imm, rs1, f3, rd, op};
    endfunction

    task automatic put(input logic [31:0] word, input logic we, input logic [4:0] rd,
                       input logic [XLEN-1:0] val, input logic [XLEN-1:0] nxt);
        rom[pcw]      = word;
        exp_we[pcw]   = we;
        exp_rd[pcw]   = rd;
        exp_val[pcw]  = val;
        exp_next[pcw] = nxt;
        if (we && rd != 0) sreg[rd] = val;
        pcw++;
    endtask

    // filler word that only runs if a branch or jump goes wrong
    task automatic skip_slot();
        rom[pcw] = enc_i(7'h13, 5'd31, 3'b000, 5'd31, 12'h7ff);
        pcw++;
    endtask

    task automatic op_addi(input logic [4:0] rd, input logic [4:0] rs1, input logic [11:0] imm);
        put(enc_i(7'h13, rd, 3'b000, rs1, imm), 1'b1, rd, sreg[rs1] + sext12(imm), (pcw + 1) * 4);
    endtask

    // register ops by the ISA rules
    task automatic op_reg(input logic [6:0] f7, input logic [2:0] f3, input logic w,
                          input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2);
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] r;
        a = sreg[rs1];
        b = sreg[rs2];
        case (f3)
            3'b000: r = f7[5] ? a - b : a + b;
            3'b001: r = a << b[5:0];
            3'b010: r = {63'b0, $signed(a) < $signed(b)};
            3'b011: r = {63'b0, a < b};
            3'b100: r = a ^ b;
            3'b101: begin
                if (f7[5]) begin
                    r = $signed(a) >>> b[5:0];
                end else begin
                    r = a >> b[5:0];
                end
            end
            3'b110: r = a | b;
            default: r = a & b;
        endcase
        if (w) r = {{32{r[31]}}, r[31:0]};
        put({f7, rs2, rs1, f3, rd, w ? 7'h3b : 7'h33}, 1'b1, rd, r, (pcw + 1) * 4);
    endtask

    task automatic op_branch(input logic [2:0] f3, input logic [4:0] rs1, input logic [4:0] rs2);
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic            t;
        a = sreg[rs1];
        b = sreg[rs2];
        case (f3)
            3'b000: t = (a == b);
            3'b001: t = (a != b);
            3'b100: t = ($signed(a) < $signed(b));
            3'b101: t = ($signed(a) >= $signed(b));
            3'b110: t = (a < b);
            default: t = (a >= b);
        endcase
        // offset +8 skips one word
        put({1'b0, 6'd0, rs2, rs1, f3, 4'd4, 1'b0, 7'h63}, 1'b0, 5'd0, '0,
            t ? (pcw + 2) * 4 : (pcw + 1) * 4);
        if (t) skip_slot();
    endtask

    task automatic op_store(input logic [1:0] sz, input logic [4:0] rs2, input logic [4:0] rs1,
                            input logic [11:0] off);
        logic [XLEN-1:0] a;
        a = sreg[rs1] + sext12(off);
        for (int i = 0; i < (1 << sz); i++) smem[(a + i) % 2048] = sreg[rs2] >> (8 * i);
        put({off[11:5], rs2, rs1, 1'b0, sz, off[4:0], 7'h23}, 1'b0, 5'd0, '0, (pcw + 1) * 4);
    endtask

    task automatic op_load(input logic [2:0] f3, input logic [4:0] rd, input logic [4:0] rs1,
                           input logic [11:0] off);
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] r;
        int              n;
        a = sreg[rs1] + sext12(off);
        n = 1 << f3[1:0];
        r = '0;
        for (int i = 0; i < n; i++) r = r | (XLEN'(smem[(a + i) % 2048]) << (8 * i));
        if (!f3[2] && n < 8 && r[8*n-1]) r = r | (~64'h0 << (8 * n));
        put(enc_i(7'h03, rd, f3, rs1, off), 1'b1, rd, r, (pcw + 1) * 4);
    endtask

    task automatic build_program();
        int base;
        pcw = 0;
        for (int i = 0; i < 32; i++) sreg[i] = '0;
        for (int i = 0; i < 64; i++) begin
            rom[i] = 32'h0;
            exp_next[i] = '1;
        end
        for (int r = 1; r <= 4; r++) op_addi(r, 0, 12'($urandom));
        op_reg(7'h00, 3'b000, 0, 5, 1, 2);
        op_reg(7'h20, 3'b000, 0, 6, 1, 3);
        op_reg(7'h00, 3'b111, 0, 7, 2, 4);
        op_reg(7'h00, 3'b110, 0, 8, 3, 4);
        op_reg(7'h00, 3'b100, 0, 9, 1, 4);
        op_reg(7'h00, 3'b010, 0, 10, 6, 2);
        op_reg(7'h00, 3'b011, 0, 11, 6, 3);
        op_reg(7'h00, 3'b001, 0, 12, 6, 2);
        op_reg(7'h00, 3'b101, 0, 13, 6, 3);
        op_reg(7'h20, 3'b101, 0, 14, 6, 4);
        op_reg(7'h00, 3'b000, 1, 15, 12, 6);
        op_reg(7'h20, 3'b000, 1, 16, 6, 12);
        // a write to x0 is dropped and x0 still reads zero
        put(enc_i(7'h13, 5'd0, 3'b000, 5'd1, 12'h123), 1'b0, 5'd0, '0, (pcw + 1) * 4);
        op_reg(7'h00, 3'b000, 0, 17, 0, 1);
        op_addi(22, 0, 12'hfff);               // -1
        op_addi(23, 0, 12'h001);
        op_branch(3'b000, 1, 1);
        op_branch(3'b000, 22, 23);
        op_branch(3'b001, 22, 23);
        op_branch(3'b001, 1, 1);
        op_branch(3'b100, 22, 23);
        op_branch(3'b100, 23, 22);
        op_branch(3'b101, 23, 22);
        op_branch(3'b101, 22, 23);
        op_branch(3'b110, 23, 22);
        op_branch(3'b110, 22, 23);
        op_branch(3'b111, 22, 23);
        op_branch(3'b111, 23, 22);
        put({1'b0, 10'd4, 1'b0, 8'd0, 5'd17, 7'h6f}, 1'b1, 5'd17, pcw * 4 + 4, (pcw + 2) * 4);
        skip_slot();
        base = (pcw + 3) * 4;                   // jalr target past its filler
        op_addi(18, 0, 12'(base));
        put(enc_i(7'h67, 5'd19, 3'b000, 5'd18, 12'h001), 1'b1, 5'd19, pcw * 4 + 4, base);
        skip_slot();
        op_addi(20, 0, 12'd64);
        op_addi(21, 0, 12'haaa);
        op_store(2'd3, 21, 20, 12'd0);
        op_store(2'd3, 7, 20, 12'd8);
        op_load(3'b011, 24, 20, 12'd0);
        op_load(3'b010, 25, 20, 12'd4);
        op_load(3'b001, 26, 20, 12'd2);
        op_load(3'b000, 27, 20, 12'd1);
        op_load(3'b110, 28, 20, 12'd4);
        op_load(3'b101, 29, 20, 12'd6);
        op_load(3'b100, 30, 20, 12'd0);
        op_store(2'd0, 1, 20, 12'd5);
        op_store(2'd1, 2, 20, 12'd2);
        op_store(2'd2, 3, 20, 12'd12);
        op_load(3'b011, 24, 20, 12'd0);
        op_load(3'b011, 25, 20, 12'd8);
        put(32'h0, 1'b0, 5'd0, '0, pcw * 4);   // illegal word where the pc parks
    endtask

    // outputs are stable at the falling edge
    always @(negedge clk) begin
        if (!rst) begin
            cur_idx = int'(retire_pc[7:2]);
            checks++;
            if (have_prev) begin
                assert (retire_pc == exp_next[prev_idx]) else begin
                    $display("CHECK FAILED at %0t: pc %0h, expected %0h", $time, retire_pc,
                             exp_next[prev_idx]);
                    errors++;
                end
            end
            assert (wb_we == exp_we[cur_idx]) else begin
                $display("CHECK FAILED at %0t: wb_we %0b at pc %0h", $time, wb_we, retire_pc);
                errors++;
            end
            if (wb_we) begin
                assert (wb_addr == exp_rd[cur_idx] && wb_data == exp_val[cur_idx]) else begin
                    $display("CHECK FAILED at %0t: x%0d = %0h, expected x%0d = %0h", $time,
                             wb_addr, wb_data, exp_rd[cur_idx], exp_val[cur_idx]);
                    errors++;
                end
            end
            prev_idx  = cur_idx;
            have_prev = 1'b1;
        end
    end

    initial begin
        int cycles;
        rst       = 1'b1;
        errors    = 0;
        checks    = 0;
        have_prev = 1'b0;
        void'($urandom(32'h5231d07c));
        build_program();
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        cycles = 0;
        while (!illegal && cycles < 200) begin
            @(negedge clk);
            cycles++;
        end
        if (!illegal) begin
            $display("timeout: the core never reached the illegal word");
            errors++;
        end
        cycles = 0;
        while (cycles < 4) begin               // let the hold be observed
            @(negedge clk);
            cycles++;
        end
        $display("summary: %0d cycles checked, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: sim/rv_core_sva.sv
`timescale 1ns/100ps

module rv_core_sva import rv_pkg::*; (
    input logic            clk,
    input logic            rst,
    input logic [XLEN-1:0] imem_addr,
    input logic [31:0]     imem_data,
    input logic [XLEN-1:0] retire_pc,
    input logic            wb_we,
    input logic [4:0]      wb_addr,
    input logic            illegal
);
    logic xfer;

    // branches and jumps leave the +4 sequence
    assign xfer = (imem_data[6:0] == OP_BRANCH) || (imem_data[6:0] == OP_JAL)
               || (imem_data[6:0] == OP_JALR);

    a_reset_quiet: assert property (@(posedge clk) rst |-> !wb_we)
        else $error("write strobe active in reset");

    a_reset_pc: assert property (@(posedge clk) rst |=> imem_addr == RESET_PC)
        else $error("pc not at reset address");

    a_sequential: assert property (@(posedge clk) disable iff (rst)
        !illegal && !xfer |=> retire_pc == $past(retire_pc) + 64'd4)
        else $error("pc did not advance by 4");

    a_no_x0: assert property (@(posedge clk) wb_we |-> wb_addr != 5'd0)
        else $error("write reported for x0");

    a_illegal_hold: assert property (@(posedge clk) disable iff (rst)
        illegal |=> illegal && retire_pc == $past(retire_pc))
        else $error("pc moved on an illegal word");

    a_illegal_quiet: assert property (@(posedge clk) illegal |-> !wb_we)
        else $error("register write while illegal");

endmodule

// File: logic/rv_core.sv
`timescale 1ns/100ps

module rv_core import rv_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    output logic [XLEN-1:0] imem_addr,
    input  logic [31:0]     imem_data,
    output logic [XLEN-1:0] retire_pc,
    output logic            wb_we,
    output logic [4:0]      wb_addr,
    output logic [XLEN-1:0] wb_data,
    output logic            illegal
);
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] rs1_data, rs2_data, imm;
    logic [XLEN-1:0] alu_a, alu_b, alu_result, load_data;
    alu_op_e         alu_op;
    src1_sel_e       src1_sel;
    src2_sel_e       src2_sel;
    imm_sel_e        imm_sel;
    pc_sel_e         pc_sel;
    wb_sel_e         wb_sel;
    mem_size_e       mem_size;
    logic            word_op, rf_we, mem_en, mem_we, mem_unsigned;

    rv_control u_control (
        .rst(rst), .instr(imem_data),
        .alu_op(alu_op), .src1_sel(src1_sel), .src2_sel(src2_sel), .imm_sel(imm_sel),
        .word_op(word_op), .pc_sel(pc_sel), .rf_we(rf_we), .wb_sel(wb_sel),
        .mem_en(mem_en), .mem_we(mem_we), .mem_size(mem_size),
        .mem_unsigned(mem_unsigned), .illegal(illegal)
    );

    rv_regfile u_regfile (
        .clk(clk), .rs1_addr(imem_data[19:15]), .rs2_addr(imem_data[24:20]),
        .rd_addr(imem_data[11:7]), .rd_we(rf_we), .rd_data(wb_data),
        .rs1_data(rs1_data), .rs2_data(rs2_data)
    );

    rv_imm_gen u_imm_gen (.instr(imem_data), .imm_sel(imm_sel), .imm(imm));

    // operand muxes, jal and jalr link through pc + 4
    assign alu_a = (src1_sel == S1_PC) ? pc : rs1_data;
    assign alu_b = (src2_sel == S2_REG)  ? rs2_data   :
                   (src2_sel == S2_FOUR) ? XLEN'(4) : imm;

    rv_alu u_alu (.alu_op(alu_op), .word_op(word_op), .a(alu_a), .b(alu_b), .result(alu_result));

    rv_pc_unit u_pc_unit (
        .clk(clk), .rst(rst), .pc_sel(pc_sel), .funct3(imem_data[14:12]),
        .rs1_data(rs1_data), .rs2_data(rs2_data), .imm(imm), .illegal(illegal), .pc(pc)
    );

    rv_lsu u_lsu (
        .clk(clk), .mem_en(mem_en), .mem_we(mem_we), .mem_size(mem_size),
        .mem_unsigned(mem_unsigned), .addr(alu_result), .store_data(rs2_data),
        .load_data(load_data)
    );

    assign wb_data   = (wb_sel == WB_MEM) ? load_data : alu_result;
    assign imem_addr = pc;
    assign retire_pc = pc;  // the instruction executing now
    assign wb_we     = rf_we;
    assign wb_addr   = imem_data[11:7];

endmodule

// File: logic/rv_lsu.sv
`timescale 1ns/100ps

module rv_lsu import rv_pkg::*; (
    input  logic            clk,
    input  logic            mem_en,
    input  logic            mem_we,
    input  mem_size_e       mem_size,
    input  logic            mem_unsigned,
    input  logic [XLEN-1:0] addr,
    input  logic [XLEN-1:0] store_data,
    output logic [XLEN-1:0] load_data
);
    logic [XLEN-1:0]    mem [DMEM_WORDS];
    logic [DMEM_AW-1:0] idx;
    logic [2:0]         off;
    logic [7:0]         lane_mask;
    logic [XLEN-1:0]    wdata_sh;
    logic [XLEN-1:0]    rdata_sh;

    assign idx = addr[3 +: DMEM_AW];  // wraps inside the ram
    assign off = addr[2:0];

    always_comb begin
        case (mem_size)
            SZ_B:    lane_mask = 8'h01 << off;
            SZ_H:    lane_mask = 8'h03 << off;
            SZ_W:    lane_mask = 8'h0f << off;
            default: lane_mask = 8'hff;
        endcase
    end

    assign wdata_sh = store_data << {off, 3'b000};

    always_ff @(posedge clk) begin
        if (mem_en && mem_we) begin
            for (int i = 0; i < 8; i++) begin
                if (lane_mask[i]) begin
                    mem[idx][i*8 +: 8] <= wdata_sh[i*8 +: 8];
                end
            end
        end
    end

    // addressed lane moved down to bit 0
    assign rdata_sh = mem[idx] >> {off, 3'b000};

    always_comb begin
        load_data = '0;
        if (mem_en) begin
            case (mem_size)
                SZ_B: load_data = {{(XLEN-8){~mem_unsigned & rdata_sh[7]}}, rdata_sh[7:0]};
                SZ_H: load_data = {{(XLEN-16){~mem_unsigned & rdata_sh[15]}}, rdata_sh[15:0]};
                SZ_W: load_data = {{(XLEN-32){~mem_unsigned & rdata_sh[31]}}, rdata_sh[31:0]};
                default: load_data = rdata_sh;
            endcase
        end
    end

endmodule

// File: logic/rv_pc_unit.sv
`timescale 1ns/100ps

module rv_pc_unit import rv_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  pc_sel_e         pc_sel,
    input  logic [2:0]      funct3,
    input  logic [XLEN-1:0] rs1_data,
    input  logic [XLEN-1:0] rs2_data,
    input  logic [XLEN-1:0] imm,
    input  logic            illegal,
    output logic [XLEN-1:0] pc
);
    logic            taken;
    logic [XLEN-1:0] pc_plus4;
    logic [XLEN-1:0] pc_rel;
    logic [XLEN-1:0] jalr_sum;
    logic [XLEN-1:0] pc_next;

    always_comb begin
        case (funct3)
            3'b000:  taken = (rs1_data == rs2_data);
            3'b001:  taken = (rs1_data != rs2_data);
            3'b100:  taken = ($signed(rs1_data) < $signed(rs2_data));
            3'b101:  taken = ($signed(rs1_data) >= $signed(rs2_data));
            3'b110:  taken = (rs1_data < rs2_data);
            3'b111:  taken = (rs1_data >= rs2_data);
            default: taken = 1'b0;
        endcase
    end

    assign pc_plus4 = pc + XLEN'(4);
    assign pc_rel   = pc + imm;
    assign jalr_sum = rs1_data + imm;

    always_comb begin
        case (pc_sel)
            PC_BRANCH: pc_next = taken ? pc_rel : pc_plus4;
            PC_JAL:    pc_next = pc_rel;
            PC_JALR:   pc_next = {jalr_sum[XLEN-1:1], 1'b0};  // lsb cleared
            default:   pc_next = pc_plus4;
        endcase
    end

    // parks on an illegal word until reset
    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= RESET_PC;
        end else if (!illegal) begin
            pc <= pc_next;
        end
    end

endmodule

// File: logic/rv_alu.sv
`timescale 1ns/100ps

module rv_alu import rv_pkg::*; (
    input  alu_op_e         alu_op,
    input  logic            word_op,
    input  logic [XLEN-1:0] a,
    input  logic [XLEN-1:0] b,
    output logic [XLEN-1:0] result
);
    logic [5:0]      shamt;
    logic [XLEN-1:0] sh_src;
    logic [XLEN-1:0] raw;

    assign shamt = word_op ? {1'b0, b[4:0]} : b[5:0];

    // word shifts only see the low half of a
    always_comb begin
        sh_src = a;
        if (word_op) begin
            sh_src = (alu_op == ALU_SRA) ? {{(XLEN-32){a[31]}}, a[31:0]}
                                         : {{(XLEN-32){1'b0}}, a[31:0]};
        end
    end

    always_comb begin
        case (alu_op)
            ALU_ADD:    raw = a + b;
            ALU_SUB:    raw = a - b;
            ALU_SLT:    raw = XLEN'($signed(a) < $signed(b));
            ALU_SLTU:   raw = XLEN'(a < b);
            ALU_AND:    raw = a & b;
            ALU_OR:     raw = a | b;
            ALU_XOR:    raw = a ^ b;
            ALU_SLL:    raw = sh_src << shamt;
            ALU_SRL:    raw = sh_src >> shamt;
            ALU_SRA:    raw = $signed(sh_src) >>> shamt;
            ALU_PASS_B: raw = b;
            default:    raw = '0;
        endcase
    end

    assign result = word_op ? {{(XLEN-32){raw[31]}}, raw[31:0]} : raw;  // *w results

endmodule

// File: logic/rv_imm_gen.sv
`timescale 1ns/100ps

module rv_imm_gen import rv_pkg::*; (
    input  logic [31:0]     instr,
    input  imm_sel_e        imm_sel,
    output logic [XLEN-1:0] imm
);
    logic sign;

    assign sign = instr[31];

    always_comb begin
        case (imm_sel)
            IMM_I: imm = {{(XLEN-12){sign}}, instr[31:20]};
            IMM_S: imm = {{(XLEN-12){sign}}, instr[31:25], instr[11:7]};
            // branch and jump offsets are in halfwords
            IMM_B: imm = {{(XLEN-12){sign}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            IMM_U: imm = {{(XLEN-32){sign}}, instr[31:12], 12'b0};
            IMM_J: imm = {{(XLEN-20){sign}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            default: imm = '0;
        endcase
    end

endmodule

// File: logic/rv_regfile.sv
`timescale 1ns/100ps

module rv_regfile import rv_pkg::*; (
    input  logic            clk,
    input  logic [4:0]      rs1_addr,
    input  logic [4:0]      rs2_addr,
    input  logic [4:0]      rd_addr,
    input  logic            rd_we,
    input  logic [XLEN-1:0] rd_data,
    output logic [XLEN-1:0] rs1_data,
    output logic [XLEN-1:0] rs2_data
);
    logic [XLEN-1:0] regs [32];

    always_ff @(posedge clk) begin
        if (rd_we && (rd_addr != 5'd0)) begin
            regs[rd_addr] <= rd_data;
        end
    end

    // x0 is hardwired
    assign rs1_data = (rs1_addr == 5'd0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == 5'd0) ? '0 : regs[rs2_addr];

endmodule

// File: logic/rv_control.sv
`timescale 1ns/100ps

module rv_control import rv_pkg::*; (
    input  logic        rst,
    input  logic [31:0] instr,
    output alu_op_e     alu_op,
    output src1_sel_e   src1_sel,
    output src2_sel_e   src2_sel,
    output imm_sel_e    imm_sel,
    output logic        word_op,
    output pc_sel_e     pc_sel,
    output logic        rf_we,
    output wb_sel_e     wb_sel,
    output logic        mem_en,
    output logic        mem_we,
    output mem_size_e   mem_size,
    output logic        mem_unsigned,
    output logic        illegal
);
    opcode_e    opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic [4:0] rd;

    logic inst_addi, inst_andi, inst_sltiu, inst_slli, inst_srli, inst_srai, inst_addiw;
    logic inst_lui, inst_auipc, inst_jal, inst_jalr;
    logic inst_add, inst_sub, inst_and, inst_or, inst_xor;
    logic inst_slt, inst_sltu, inst_sll, inst_srl, inst_sra;
    logic inst_addw, inst_subw;
    logic inst_beq, inst_bne, inst_blt, inst_bge, inst_bltu, inst_bgeu;
    logic inst_ld, inst_lw, inst_lh, inst_lb, inst_lwu, inst_lhu, inst_lbu;
    logic inst_sd, inst_sw, inst_sh, inst_sb;
    logic i_type, r_type, b_type, load, store, legal, writes_rd;

    assign opcode = opcode_e'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign rd     = instr[11:7];

    // immediate alu group, shamt bit 5 lives in funct7[0]
    assign inst_addi  = (opcode == OP_IMM) && (funct3 == 3'b000);
    assign inst_sltiu = (opcode == OP_IMM) && (funct3 == 3'b011);
    assign inst_andi  = (opcode == OP_IMM) && (funct3 == 3'b111);
    assign inst_slli  = (opcode == OP_IMM) && (funct3 == 3'b001) && (funct7[6:1] == 6'b000000);
    assign inst_srli  = (opcode == OP_IMM) && (funct3 == 3'b101) && (funct7[6:1] == 6'b000000);
    assign inst_srai  = (opcode == OP_IMM) && (funct3 == 3'b101) && (funct7[6:1] == 6'b010000);
    assign inst_addiw = (opcode == OP_IMM_W) && (funct3 == 3'b000);

    assign inst_lui   = (opcode == OP_LUI);
    assign inst_auipc = (opcode == OP_AUIPC);
    assign inst_jal   = (opcode == OP_JAL);
    assign inst_jalr  = (opcode == OP_JALR) && (funct3 == 3'b000);

    assign inst_add  = (opcode == OP_REG) && (funct3 == 3'b000) && (funct7 == 7'b0000000);
    assign inst_sub  = (opcode == OP_REG) && (funct3 == 3'b000) && (funct7 == 7'b0100000);
    assign inst_sll  = (opcode == OP_REG) && (funct3 == 3'b001) && (funct7 == 7'b0000000);
    assign inst_slt  = (opcode == OP_REG) && (funct3 == 3'b010) && (funct7 == 7'b0000000);
    assign inst_sltu = (opcode == OP_REG) && (funct3 == 3'b011) && (funct7 == 7'b0000000);
    assign inst_xor  = (opcode == OP_REG) && (funct3 == 3'b100) && (funct7 == 7'b0000000);
    assign inst_srl  = (opcode == OP_REG) && (funct3 == 3'b101) && (funct7 == 7'b0000000);
    assign inst_sra  = (opcode == OP_REG) && (funct3 == 3'b101) && (funct7 == 7'b0100000);
    assign inst_or   = (opcode == OP_REG) && (funct3 == 3'b110) && (funct7 == 7'b0000000);
    assign inst_and  = (opcode == OP_REG) && (funct3 == 3'b111) && (funct7 == 7'b0000000);
    assign inst_addw = (opcode == OP_REG_W) && (funct3 == 3'b000) && (funct7 == 7'b0000000);
    assign inst_subw = (opcode == OP_REG_W) && (funct3 == 3'b000) && (funct7 == 7'b0100000);

    assign inst_beq  = (opcode == OP_BRANCH) && (funct3 == 3'b000);
    assign inst_bne  = (opcode == OP_BRANCH) && (funct3 == 3'b001);
    assign inst_blt  = (opcode == OP_BRANCH) && (funct3 == 3'b100);
    assign inst_bge  = (opcode == OP_BRANCH) && (funct3 == 3'b101);
    assign inst_bltu = (opcode == OP_BRANCH) && (funct3 == 3'b110);
    assign inst_bgeu = (opcode == OP_BRANCH) && (funct3 == 3'b111);

    assign inst_lb  = (opcode == OP_LOAD) && (funct3 == 3'b000);
    assign inst_lh  = (opcode == OP_LOAD) && (funct3 == 3'b001);
    assign inst_lw  = (opcode == OP_LOAD) && (funct3 == 3'b010);
    assign inst_ld  = (opcode == OP_LOAD) && (funct3 == 3'b011);
    assign inst_lbu = (opcode == OP_LOAD) && (funct3 == 3'b100);
    assign inst_lhu = (opcode == OP_LOAD) && (funct3 == 3'b101);
    assign inst_lwu = (opcode == OP_LOAD) && (funct3 == 3'b110);

    assign inst_sb = (opcode == OP_STORE) && (funct3 == 3'b000);
    assign inst_sh = (opcode == OP_STORE) && (funct3 == 3'b001);
    assign inst_sw = (opcode == OP_STORE) && (funct3 == 3'b010);
    assign inst_sd = (opcode == OP_STORE) && (funct3 == 3'b011);

    // instruction classes
    assign i_type = inst_addi | inst_andi | inst_sltiu | inst_slli | inst_srli | inst_srai
                  | inst_addiw;
    assign r_type = inst_add | inst_sub | inst_and | inst_or | inst_xor | inst_slt | inst_sltu
                  | inst_sll | inst_srl | inst_sra | inst_addw | inst_subw;
    assign b_type = inst_beq | inst_bne | inst_blt | inst_bge | inst_bltu | inst_bgeu;
    assign load   = inst_ld | inst_lw | inst_lh | inst_lb | inst_lwu | inst_lhu | inst_lbu;
    assign store  = inst_sd | inst_sw | inst_sh | inst_sb;

    assign writes_rd = i_type | r_type | load | inst_lui | inst_auipc | inst_jal | inst_jalr;
    assign legal     = writes_rd | b_type | store;

    always_comb begin
        alu_op = ALU_ADD;                        // also addresses, auipc, links
        if (inst_sub | inst_subw)       alu_op = ALU_SUB;
        else if (inst_slt)              alu_op = ALU_SLT;
        else if (inst_sltu | inst_sltiu) alu_op = ALU_SLTU;
        else if (inst_and | inst_andi)  alu_op = ALU_AND;
        else if (inst_or)               alu_op = ALU_OR;
        else if (inst_xor)              alu_op = ALU_XOR;
        else if (inst_sll | inst_slli)  alu_op = ALU_SLL;
        else if (inst_srl | inst_srli)  alu_op = ALU_SRL;
        else if (inst_sra | inst_srai)  alu_op = ALU_SRA;
        else if (inst_lui)              alu_op = ALU_PASS_B;
    end

    assign src1_sel = (inst_auipc | inst_jal | inst_jalr) ? S1_PC : S1_REG;
    assign src2_sel = (r_type | b_type)      ? S2_REG  :
                      (inst_jal | inst_jalr) ? S2_FOUR : S2_IMM;
    assign imm_sel  = store                  ? IMM_S :
                      b_type                 ? IMM_B :
                      (inst_lui | inst_auipc) ? IMM_U :
                      inst_jal               ? IMM_J : IMM_I;
    assign word_op  = inst_addiw | inst_addw | inst_subw;

    assign pc_sel = b_type    ? PC_BRANCH :
                    inst_jal  ? PC_JAL    :
                    inst_jalr ? PC_JALR   : PC_SEQ;

    assign rf_we        = ~rst & writes_rd & (rd != 5'd0);  // x0 never written
    assign wb_sel       = load ? WB_MEM : WB_ALU;
    assign mem_en       = load | store;
    assign mem_we       = ~rst & store;
    assign mem_size     = mem_size_e'(funct3[1:0]);
    assign mem_unsigned = load & funct3[2];
    assign illegal      = ~rst & ~legal;

endmodule

// File: logic/rv_pkg.sv
package rv_pkg;

    localparam int XLEN       = 64;
    localparam logic [XLEN-1:0] RESET_PC = '0;
    localparam int DMEM_WORDS = 256;             // doublewords
    localparam int DMEM_AW    = $clog2(DMEM_WORDS);

    // major opcodes of the kept subset
    typedef enum logic [6:0] {
        OP_LOAD   = 7'b0000011,
        OP_IMM    = 7'b0010011,
        OP_AUIPC  = 7'b0010111,
        OP_IMM_W  = 7'b0011011,
        OP_STORE  = 7'b0100011,
        OP_REG    = 7'b0110011,
        OP_LUI    = 7'b0110111,
        OP_REG_W  = 7'b0111011,
        OP_BRANCH = 7'b1100011,
        OP_JALR   = 7'b1100111,
        OP_JAL    = 7'b1101111
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_SLTU,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_PASS_B                               // lui
    } alu_op_e;

    typedef enum logic {S1_REG, S1_PC} src1_sel_e;

    typedef enum logic [1:0] {S2_REG, S2_IMM, S2_FOUR} src2_sel_e;

    typedef enum logic [2:0] {IMM_I, IMM_S, IMM_B, IMM_U, IMM_J} imm_sel_e;

    typedef enum logic [1:0] {PC_SEQ, PC_BRANCH, PC_JAL, PC_JALR} pc_sel_e;

    typedef enum logic {WB_ALU, WB_MEM} wb_sel_e;

    // same order as funct3[1:0] of loads and stores
    typedef enum logic [1:0] {
        SZ_B,
        SZ_H,
        SZ_W,
        SZ_D
    } mem_size_e;

endpackage
